// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module pipelineControlTb -Mdir "$buildDir" -o pipelineControlTb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$buildDir/pipelineControlTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "=== FAIL ===" "$logFile"; then
    exit 1
fi
exit 0

// ==== sim/pipelineChecker.sv ====
`timescale 1ns/1ns

module pipelineChecker (
    input logic                          clk,
    input logic                          rst,
    input logic [31:0]                   instrId,
    input logic [31:0]                   pcIf,
    input logic                          bdIf,
    input logic [31:0]                   pcId,
    input logic                          bdId,
    input logic [pipeCtrlPkg::EXC_W-1:0] excId,
    input pipeCtrlPkg::kCtrl_e           kCtrl,
    input pipeCtrlPkg::stallCtrl_t       ctrl,
    input logic [31:0]                   macroPc,
    input logic                          macroBd
);
    import pipeCtrlPkg::*;

    // what the ID word needs and produces
    typedef struct packed {
        logic [4:0]        dest;
        logic [TIME_W-1:0] tuseRs;
        logic [TIME_W-1:0] tuseRt;
        logic [TIME_W-1:0] tnew;
    } refInfo_t;

    typedef struct packed {
        stallCtrl_t  ctrl;
        logic [31:0] pc;
        logic        bd;
    } refOut_t;

    stageRec_t shEx = '0;
    stageRec_t shMem = '0;
    logic      primed = 1'b0;
    string     curTest = "";
    int        testCount = 0;
    int        checkCount = 0;
    int        errorCount = 0;
    int        testChecks = 0;
    int        testErrors = 0;

    function automatic refInfo_t refDecode(input logic [31:0] ins);
        refInfo_t r;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        rs = ins[25:21];
        rt = ins[20:16];
        rd = ins[15:11];
        r = {5'd0, TUSE_INF, TUSE_INF, 2'd0};
        if (ins != 32'h0) begin
            case (ins[31:26])
                6'h00: begin
                    case (ins[5:0])
                        6'h21, 6'h23, 6'h25, 6'h2a: r = {rd, 2'd1, 2'd1, 2'd2};
                        6'h00, 6'h02, 6'h03: r = {rd, TUSE_INF, 2'd1, 2'd2};
                        6'h08: r = {5'd0, 2'd0, TUSE_INF, 2'd0};
                        6'h09: r = {rd, 2'd0, TUSE_INF, 2'd1};
                        default: ;
                    endcase
                end
                6'h09, 6'h0d: r = {rt, 2'd1, TUSE_INF, 2'd2};
                6'h0f: r = {rt, TUSE_INF, TUSE_INF, 2'd1};
                // lb shares the lw latency in this model
                6'h20, 6'h23: r = {rt, 2'd1, TUSE_INF, 2'd3};
                6'h2b: r = {5'd0, 2'd1, 2'd2, 2'd0};
                6'h04, 6'h05: r = {5'd0, 2'd0, 2'd0, 2'd0};
                6'h01: begin
                    if (rt == 5'd1) begin
                        r = {5'd0, 2'd0, TUSE_INF, 2'd0};
                    end
                end
                6'h03: r = {5'd31, TUSE_INF, TUSE_INF, 2'd1};
                6'h10: begin
                    if (rs == 5'd0) begin
                        r = {rt, TUSE_INF, TUSE_INF, 2'd3};
                    end else if (rs == 5'd4) begin
                        r = {5'd0, TUSE_INF, 2'd2, 2'd0};
                    end
                end
                default: ;
            endcase
        end
        return r;
    endfunction

    function automatic logic blocked(input logic [4:0] src, input logic [TIME_W-1:0] tuse);
        if (src == 5'd0 || tuse == TUSE_INF) begin
            return 1'b0;
        end
        return (shEx.dest == src && shEx.tnew > tuse) || (shMem.dest == src && shMem.tnew > tuse);
    endfunction

    // expected outputs from the current ID inputs and the shadow records
    function automatic refOut_t refExpect();
        refOut_t  r;
        refInfo_t info;
        logic     stall;
        logic     flush;
        info = refDecode(instrId);
        stall = blocked(instrId[25:21], info.tuseRs) || blocked(instrId[20:16], info.tuseRt);
        flush = (kCtrl == KCTRL_KTEXT) || (kCtrl == KCTRL_ERET);
        r.ctrl = '0;
        r.ctrl.stallPc = stall && !flush;
        r.ctrl.stallId = stall && !flush;
        r.ctrl.clrEx = stall || flush;
        r.ctrl.clrId = flush;
        r.ctrl.clrMem = flush;
        r.ctrl.clrWb = flush;
        r.ctrl.disMultDiv = flush;
        r.ctrl.disDm = flush;
        r.pc = 32'h0;
        r.bd = 1'b0;
        if (shMem.pc != 32'h0 || shMem.exc != '0) begin
            r.pc = shMem.pc;
            r.bd = shMem.bd;
        end else if (shEx.pc != 32'h0 || shEx.exc != '0) begin
            r.pc = shEx.pc;
            r.bd = shEx.bd;
        end else if (pcId != 32'h0 || excId != '0) begin
            r.pc = pcId;
            r.bd = bdId;
        end else if (pcIf != 32'h0) begin
            r.pc = pcIf;
            r.bd = bdIf;
        end
        return r;
    endfunction

    function automatic stageRec_t countDown(input stageRec_t rec);
        stageRec_t r;
        r = rec;
        if (rec.tnew != '0) begin
            r.tnew = rec.tnew - TIME_W'(1);
        end
        return r;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
        errorCount++;
        testErrors++;
        $display("ERROR %s: %s expected 0x%h actual 0x%h", curTest, what, exp, act);
    endtask

    task automatic expectValue(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checkCount++;
        testChecks++;
        if (act !== exp) begin
            reportMismatch(what, exp, act);
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic endTest();
        testCount++;
        $display("test %-14s checks %0d errors %0d", curTest, testChecks, testErrors);
    endtask

    // shadow pipeline updated oldest stage first so each reads the old value
    always @(posedge clk) begin : advance
        refOut_t   e;
        refInfo_t  info;
        stageRec_t idRec;
        e = refExpect();
        info = refDecode(instrId);
        idRec = '0;
        idRec.pc = pcId;
        idRec.bd = bdId;
        idRec.exc = excId;
        idRec.dest = info.dest;
        idRec.tnew = info.tnew;
        shMem = (rst || e.ctrl.clrMem) ? '0 : countDown(shEx);
        shEx = (rst || e.ctrl.clrEx) ? '0 : countDown(idRec);
        primed = 1'b1;
    end

    // outputs are settled half a cycle after the inputs change
    always @(negedge clk) begin : compare
        refOut_t e;
        if (primed) begin
            e = refExpect();
            expectValue("ctrl", {24'd0, e.ctrl}, {24'd0, ctrl});
            expectValue("macroPc", e.pc, macroPc);
            expectValue("macroBd", {31'd0, e.bd}, {31'd0, macroBd});
        end
    end

endmodule

// ==== sim/pipelineControlTb.sv ====
`timescale 1ns/1ns

module pipelineControlTb;
    import pipeCtrlPkg::*;

    // one ID slot as presented to the DUT
    typedef struct packed {
        logic [31:0]      instr;
        logic [31:0]      pcIf;
        logic             bdIf;
        logic [31:0]      pcId;
        logic             bdId;
        logic [EXC_W-1:0] excId;
        kCtrl_e           kc;
    } idDrive_t;

    logic             clk;
    logic             rst;
    logic [31:0]      instrId;
    logic [31:0]      pcIf;
    logic             bdIf;
    logic [31:0]      pcId;
    logic             bdId;
    logic [EXC_W-1:0] excId;
    kCtrl_e           kCtrl;
    stallCtrl_t       ctrl;
    logic [31:0]      macroPc;
    logic             macroBd;
    logic [15:0]      lfsr;
    logic [31:0]      pcRun;
    int               randomCount = 400;
    // generous bound on directed slots, stalls and drains included
    int               directedCycles = 150;

    pipelineControl dut_i (
        .clk     (clk),
        .rst     (rst),
        .instrId (instrId),
        .pcIf    (pcIf),
        .bdIf    (bdIf),
        .pcId    (pcId),
        .bdId    (bdId),
        .excId   (excId),
        .kCtrl   (kCtrl),
        .ctrl    (ctrl),
        .macroPc (macroPc),
        .macroBd (macroBd)
    );

    pipelineChecker checker_i (
        .clk     (clk),
        .rst     (rst),
        .instrId (instrId),
        .pcIf    (pcIf),
        .bdIf    (bdIf),
        .pcId    (pcId),
        .bdId    (bdId),
        .excId   (excId),
        .kCtrl   (kCtrl),
        .ctrl    (ctrl),
        .macroPc (macroPc),
        .macroBd (macroBd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] rType(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] opc, input logic [4:0] rs,
                                          input logic [4:0] rt);
        return {opc, rs, rt, 16'h0010};
    endfunction

    function automatic idDrive_t idle();
        return '0;
    endfunction

    function automatic idDrive_t slot(input logic [31:0] ins, input logic [31:0] pc);
        idDrive_t d;
        d = '0;
        d.instr = ins;
        d.pcId = pc;
        d.pcIf = pc + 32'd4;
        return d;
    endfunction

    // drive one slot and hold it for as long as ID is stalled
    task automatic issue(input idDrive_t d, output int stalls);
        stalls = 0;
        @(posedge clk);
        instrId <= d.instr;
        pcIf <= d.pcIf;
        bdIf <= d.bdIf;
        pcId <= d.pcId;
        bdId <= d.bdId;
        excId <= d.excId;
        kCtrl <= d.kc;
        @(negedge clk);
        while (ctrl.stallId) begin
            stalls++;
            @(negedge clk);
        end
    endtask

    task automatic pairTest(input string what, input logic [31:0] first,
                            input logic [31:0] second, input int gap, input kCtrl_e kc,
                            input int expStalls, input logic recheck);
        idDrive_t d;
        int       stalls;
        pcRun = pcRun + 32'h100;
        issue(slot(first, pcRun), stalls);
        repeat (gap) issue(idle(), stalls);
        d = slot(second, pcRun + 32'd4);
        d.kc = kc;
        issue(d, stalls);
        checker_i.expectValue({what, " stalls"}, expStalls, stalls);
        // the flushed producer must no longer hold up the consumer
        if (recheck) begin
            d.kc = KCTRL_NONE;
            issue(d, stalls);
            checker_i.expectValue({what, " after flush"}, 0, stalls);
        end
        repeat (3) issue(idle(), stalls);
    endtask

    task automatic pickInstr(output logic [31:0] ins);
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        takeBits(4, sel);
        takeBits(3, a);
        takeBits(3, b);
        takeBits(3, c);
        case (sel[3:0])
            4'd0: ins = 32'h0;
            4'd1: ins = rType(6'h21, a[4:0], b[4:0], c[4:0]);
            4'd2: ins = rType(6'h23, a[4:0], b[4:0], c[4:0]);
            4'd3: ins = rType(6'h00, a[4:0], b[4:0], c[4:0]);
            4'd4: ins = iType(6'h0d, a[4:0], b[4:0]);
            4'd5: ins = iType(6'h0f, a[4:0], b[4:0]);
            4'd6: ins = iType(6'h23, a[4:0], b[4:0]);
            4'd7: ins = iType(6'h20, a[4:0], b[4:0]);
            4'd8: ins = iType(6'h2b, a[4:0], b[4:0]);
            4'd9: ins = iType(6'h04, a[4:0], b[4:0]);
            4'd10: ins = iType(6'h01, a[4:0], 5'd1);
            4'd11: ins = rType(6'h08, a[4:0], 5'd0, 5'd0);
            4'd12: ins = {6'h03, 26'h0000040};
            4'd13: ins = rType(6'h09, a[4:0], 5'd0, c[4:0]);
            4'd14: ins = {6'h10, 5'd0, b[4:0], 5'd12, 11'd0};
            default: ins = {6'h10, 5'd4, b[4:0], 5'd12, 11'd0};
        endcase
    endtask

    task automatic randomStream(input int count);
        idDrive_t    d;
        logic [31:0] ins;
        logic [31:0] bits;
        int          stalls;
        for (int n = 0; n < count; n++) begin
            pickInstr(ins);
            pcRun = pcRun + 32'd4;
            d = slot(ins, pcRun);
            takeBits(2, bits);
            d.bdId = bits[0];
            d.bdIf = bits[1];
            takeBits(3, bits);
            if (bits[2:0] == 3'd0) begin
                takeBits(5, bits);
                d.excId = bits[4:0];
            end
            // roughly one flush in 32 slots
            takeBits(5, bits);
            if (bits[4:0] == 5'd0) begin
                takeBits(1, bits);
                d.kc = bits[0] ? KCTRL_ERET : KCTRL_KTEXT;
            end
            issue(d, stalls);
        end
    endtask

    initial begin : watchdog
        int limitCycles;
        limitCycles = 8 + directedCycles + randomCount * 3 + 200;
        #(limitCycles * 100);
        $display("timeout: run did not finish within %0d clock cycles", limitCycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        idDrive_t d;
        int       stalls;
        rst = 1'b1;
        instrId = 32'h0;
        pcIf = 32'hbfc0_0000;
        bdIf = 1'b0;
        pcId = 32'h0;
        bdId = 1'b0;
        excId = '0;
        kCtrl = KCTRL_NONE;
        lfsr = 16'd18;
        pcRun = 32'h0040_0000;

        checker_i.startTest("reset");
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        d = idle();
        d.pcIf = 32'hbfc0_0000;
        issue(d, stalls);
        issue(d, stalls);
        checker_i.endTest();

        checker_i.startTest("loadUse");
        pairTest("lw-addu", iType(6'h23, 5'd29, 5'd8), rType(6'h21, 5'd8, 5'd10, 5'd9),
                 0, KCTRL_NONE, 1, 1'b0);
        pairTest("lw-beq", iType(6'h23, 5'd29, 5'd8), iType(6'h04, 5'd8, 5'd0),
                 0, KCTRL_NONE, 2, 1'b0);
        pairTest("addu-beq", rType(6'h21, 5'd12, 5'd13, 5'd11), iType(6'h04, 5'd0, 5'd11),
                 0, KCTRL_NONE, 1, 1'b0);
        checker_i.endTest();

        checker_i.startTest("noFalseStall");
        pairTest("zero-reg", iType(6'h23, 5'd29, 5'd0), rType(6'h21, 5'd0, 5'd0, 5'd9),
                 0, KCTRL_NONE, 0, 1'b0);
        pairTest("shift-rs", iType(6'h23, 5'd29, 5'd5), rType(6'h00, 5'd5, 5'd6, 5'd7),
                 0, KCTRL_NONE, 0, 1'b0);
        pairTest("lui", iType(6'h23, 5'd29, 5'd5), iType(6'h0f, 5'd5, 5'd5),
                 0, KCTRL_NONE, 0, 1'b0);
        pairTest("wb-producer", iType(6'h23, 5'd29, 5'd5), iType(6'h04, 5'd5, 5'd0),
                 2, KCTRL_NONE, 0, 1'b0);
        checker_i.endTest();

        checker_i.startTest("flush");
        pairTest("ktext", iType(6'h23, 5'd29, 5'd8), iType(6'h04, 5'd8, 5'd0),
                 0, KCTRL_KTEXT, 0, 1'b1);
        pairTest("eret", iType(6'h23, 5'd29, 5'd8), iType(6'h04, 5'd8, 5'd0),
                 0, KCTRL_ERET, 0, 1'b1);
        checker_i.endTest();

        // mixes of zero and nonzero pc and exc walk through the priority chain
        checker_i.startTest("macroPc");
        for (int i = 0; i < 10; i++) begin
            d = idle();
            d.pcId = (i % 3 == 0) ? 32'h0 : 32'h1000 + 32'(i) * 32'd4;
            d.excId = (i % 4 == 1) ? 5'd4 : 5'd0;
            d.bdId = i[0];
            d.bdIf = i[1];
            d.pcIf = (i > 5) ? 32'h0 : 32'h2000 + 32'(i) * 32'd4;
            issue(d, stalls);
        end
        repeat (3) issue(idle(), stalls);
        checker_i.endTest();

        checker_i.startTest("random");
        randomStream(randomCount);
        repeat (3) issue(idle(), stalls);
        checker_i.endTest();

        $display("tests %0d checks %0d errors %0d", checker_i.testCount,
                 checker_i.checkCount, checker_i.errorCount);
        if (checker_i.errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/pipeCtrlPkg.sv
verilog/instrClassifier.sv
verilog/tuseTnewDecoder.sv
verilog/hazardStall.sv
verilog/exceptionFlush.sv
verilog/stageTracker.sv
verilog/pipelineControl.sv
sim/pipelineChecker.sv
sim/pipelineControlTb.sv

// ==== verilog/exceptionFlush.sv ====
`timescale 1ns/1ns

module exceptionFlush (
    input  logic                              rawStall,
    input  pipeCtrlPkg::kCtrl_e               kCtrl,
    input  logic [31:0]                       pcIf,
    input  logic                              bdIf,
    input  logic [31:0]                       pcId,
    input  logic                              bdId,
    input  logic [pipeCtrlPkg::EXC_W-1:0]     excId,
    input  pipeCtrlPkg::stageRec_t            recEx,
    input  pipeCtrlPkg::stageRec_t            recMem,
    output pipeCtrlPkg::stallCtrl_t           ctrl,
    output logic [31:0]                       macroPc,
    output logic                              macroBd
);
    import pipeCtrlPkg::*;

    logic flushAll;

    assign flushAll = (kCtrl == KCTRL_KTEXT) || (kCtrl == KCTRL_ERET);

    // flush wins over a pending data hazard
    always_comb begin
        ctrl.stallPc    = rawStall && !flushAll;
        ctrl.stallId    = rawStall && !flushAll;
        ctrl.clrId      = flushAll;
        ctrl.clrEx      = rawStall || flushAll;
        ctrl.clrMem     = flushAll;
        ctrl.clrWb      = flushAll;
        ctrl.disMultDiv = flushAll;
        ctrl.disDm      = flushAll;
    end

    // oldest real instruction is reported to CP0
    always_comb begin
        if (recMem.pc != '0 || recMem.exc != '0) begin
            macroPc = recMem.pc;
            macroBd = recMem.bd;
        end else if (recEx.pc != '0 || recEx.exc != '0) begin
            macroPc = recEx.pc;
            macroBd = recEx.bd;
        end else if (pcId != '0 || excId != '0) begin
            macroPc = pcId;
            macroBd = bdId;
        end else if (pcIf != '0) begin
            macroPc = pcIf;
            macroBd = bdIf;
        end else begin
            macroPc = '0;
            macroBd = 1'b0;
        end
    end

endmodule

// ==== verilog/hazardStall.sv ====
`timescale 1ns/1ns

module hazardStall (
    input  pipeCtrlPkg::idInfo_t   id,
    input  pipeCtrlPkg::stageRec_t recEx,
    input  pipeCtrlPkg::stageRec_t recMem,
    output logic                   rawStall
);
    import pipeCtrlPkg::*;

    // producer still needs more cycles than the consumer can wait
    function automatic logic srcHazard(
        input logic [4:0]        src,
        input logic [TIME_W-1:0] tuse,
        input stageRec_t         ex,
        input stageRec_t         mem
    );
        logic exHit;
        logic memHit;
        exHit  = (ex.dest == src) && (ex.tnew > tuse);
        memHit = (mem.dest == src) && (mem.tnew > tuse);
        if (src == '0 || tuse == TUSE_INF) begin
            return 1'b0;
        end
        return exHit || memHit;
    endfunction

    logic stallRs;
    logic stallRt;

    assign stallRs  = srcHazard(id.rs, id.tuseRs, recEx, recMem);
    assign stallRt  = srcHazard(id.rt, id.tuseRt, recEx, recMem);
    assign rawStall = stallRs || stallRt;

endmodule

// ==== verilog/instrClassifier.sv ====
`timescale 1ns/1ns

module instrClassifier (
    input  logic [31:0]             instr,
    output pipeCtrlPkg::funcClass_e func,
    output pipeCtrlPkg::instrOp_e   op,
    output logic [4:0]              dest
);
    import pipeCtrlPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rsField;
    logic [4:0] rtField;
    logic [4:0] rdField;

    assign opcode  = instr[31:26];
    assign rsField = instr[25:21];
    assign rtField = instr[20:16];
    assign rdField = instr[15:11];
    assign funct   = instr[5:0];

    always_comb begin
        func = FUNC_NOP;
        op   = OP_UNKNOWN;
        dest = '0;
        if (instr == '0) begin
            // all-zero word is the canonical nop rather than sll $0
            op = OP_NOP;
        end else begin
            case (opcode)
                6'h00: begin
                    case (funct)
                        6'h21: op = ADDU;
                        6'h23: op = SUBU;
                        6'h00: op = SLL;
                        6'h02: op = SRL;
                        6'h03: op = SRA;
                        6'h25: op = OR;
                        6'h2a: op = SLT;
                        6'h08: op = JR;
                        6'h09: op = JALR;
                        default: op = OP_UNKNOWN;
                    endcase
                    if (op == JR) begin
                        func = FUNC_JUMP;
                    end else if (op == JALR) begin
                        func = FUNC_JUMP;
                        dest = rdField;
                    end else if (op != OP_UNKNOWN) begin
                        func = FUNC_CALC_R;
                        dest = rdField;
                    end
                end
                6'h0d: begin
                    op   = ORI;
                    func = FUNC_CALC_I;
                    dest = rtField;
                end
                6'h09: begin
                    op   = ADDIU;
                    func = FUNC_CALC_I;
                    dest = rtField;
                end
                6'h0f: begin
                    op   = LUI;
                    func = FUNC_CALC_I;
                    dest = rtField;
                end
                6'h23: begin
                    op   = LW;
                    func = FUNC_MEM_READ;
                    dest = rtField;
                end
                6'h20: begin
                    op   = LB;
                    func = FUNC_MEM_READ;
                    dest = rtField;
                end
                6'h2b: begin
                    op   = SW;
                    func = FUNC_MEM_WRITE;
                end
                6'h04: begin
                    op   = BEQ;
                    func = FUNC_BRANCH;
                end
                6'h05: begin
                    op   = BNE;
                    func = FUNC_BRANCH;
                end
                6'h01: begin
                    // only bgez is supported in the regimm group
                    if (rtField == 5'd1) begin
                        op   = BGEZ;
                        func = FUNC_BRANCH;
                    end
                end
                6'h02: begin
                    op   = J;
                    func = FUNC_JUMP;
                end
                6'h03: begin
                    op   = JAL;
                    func = FUNC_JUMP;
                    dest = REG_RA;
                end
                6'h10: begin
                    // cop0 group selected by the rs field
                    if (rsField == 5'h00) begin
                        op   = MFC0;
                        func = FUNC_CP0;
                        dest = rtField;
                    end else if (rsField == 5'h04) begin
                        op   = MTC0;
                        func = FUNC_CP0;
                    end else if (rsField == 5'h10 && funct == 6'h18) begin
                        op   = ERET;
                        func = FUNC_CP0;
                    end
                end
                default: begin
                    op = OP_UNKNOWN;
                end
            endcase
        end
    end

endmodule

// ==== verilog/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

    // width of Tuse and Tnew counters
    localparam int TIME_W = 2;
    // source register is never read by this instruction
    localparam logic [TIME_W-1:0] TUSE_INF = {TIME_W{1'b1}};

    // exception code width, zero means no exception
    localparam int EXC_W = 5;

    // link register written by JAL
    localparam logic [4:0] REG_RA = 5'd31;

    typedef enum logic [2:0] {
        FUNC_NOP,
        FUNC_CALC_R,
        FUNC_CALC_I,
        FUNC_MEM_READ,
        FUNC_MEM_WRITE,
        FUNC_BRANCH,
        FUNC_JUMP,
        FUNC_CP0
    } funcClass_e;

    // OP_NOP must stay at zero so that a bubble decodes as a NOP
    typedef enum logic [4:0] {
        OP_NOP,
        ADDU, SUBU, SLL, SRL, SRA, OR, SLT,
        ORI, ADDIU, LUI,
        LW, LB, SW,
        BEQ, BNE, BGEZ,
        J, JAL, JR, JALR,
        MFC0, MTC0, ERET,
        OP_UNKNOWN
    } instrOp_e;

    typedef enum logic [1:0] {
        KCTRL_NONE,
        KCTRL_KTEXT,
        KCTRL_ERET
    } kCtrl_e;

    // hazard record of one pipeline stage
    typedef struct packed {
        logic [31:0]       pc;
        logic              bd;
        logic [EXC_W-1:0]  exc;
        logic [4:0]        dest;
        logic [TIME_W-1:0] tnew;
        instrOp_e          op;
    } stageRec_t;

    localparam stageRec_t BUBBLE = '0;

    // decoded instruction sitting in ID
    typedef struct packed {
        instrOp_e          op;
        funcClass_e        func;
        logic [4:0]        dest;
        logic [TIME_W-1:0] tuseRs;
        logic [TIME_W-1:0] tuseRt;
        logic [TIME_W-1:0] tnew;
        logic [4:0]        rs;
        logic [4:0]        rt;
    } idInfo_t;

    typedef struct packed {
        logic stallPc;
        logic stallId;
        logic clrId;
        logic clrEx;
        logic clrMem;
        logic clrWb;
        logic disMultDiv;
        logic disDm;
    } stallCtrl_t;

endpackage

// ==== verilog/pipelineControl.sv ====
`timescale 1ns/1ns

module pipelineControl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [31:0]                   instrId,
    input  logic [31:0]                   pcIf,
    input  logic                          bdIf,
    input  logic [31:0]                   pcId,
    input  logic                          bdId,
    input  logic [pipeCtrlPkg::EXC_W-1:0] excId,
    input  pipeCtrlPkg::kCtrl_e           kCtrl,
    output pipeCtrlPkg::stallCtrl_t       ctrl,
    output logic [31:0]                   macroPc,
    output logic                          macroBd
);
    import pipeCtrlPkg::*;

    funcClass_e        idFunc;
    instrOp_e          idOp;
    logic [4:0]        idDest;
    logic [TIME_W-1:0] idTuseRs;
    logic [TIME_W-1:0] idTuseRt;
    logic [TIME_W-1:0] idTnew;
    idInfo_t           idInfo;
    stageRec_t         recEx;
    stageRec_t         recMem;
    logic              rawStall;

    instrClassifier classifier_i (
        .instr (instrId),
        .func  (idFunc),
        .op    (idOp),
        .dest  (idDest)
    );

    tuseTnewDecoder decoder_i (
        .func   (idFunc),
        .op     (idOp),
        .tuseRs (idTuseRs),
        .tuseRt (idTuseRt),
        .tnew   (idTnew)
    );

    assign idInfo = '{
        op:     idOp,
        func:   idFunc,
        dest:   idDest,
        tuseRs: idTuseRs,
        tuseRt: idTuseRt,
        tnew:   idTnew,
        rs:     instrId[25:21],
        rt:     instrId[20:16]
    };

    stageTracker tracker_i (
        .clk    (clk),
        .rst    (rst),
        .id     (idInfo),
        .pcId   (pcId),
        .bdId   (bdId),
        .excId  (excId),
        .ctrl   (ctrl),
        .recEx  (recEx),
        .recMem (recMem),
        .recWb  ()
    );

    hazardStall stall_i (
        .id       (idInfo),
        .recEx    (recEx),
        .recMem   (recMem),
        .rawStall (rawStall)
    );

    exceptionFlush flush_i (
        .rawStall (rawStall),
        .kCtrl    (kCtrl),
        .pcIf     (pcIf),
        .bdIf     (bdIf),
        .pcId     (pcId),
        .bdId     (bdId),
        .excId    (excId),
        .recEx    (recEx),
        .recMem   (recMem),
        .ctrl     (ctrl),
        .macroPc  (macroPc),
        .macroBd  (macroBd)
    );

endmodule

// ==== verilog/stageTracker.sv ====
`timescale 1ns/1ns

module stageTracker (
    input  logic                          clk,
    input  logic                          rst,
    input  pipeCtrlPkg::idInfo_t          id,
    input  logic [31:0]                   pcId,
    input  logic                          bdId,
    input  logic [pipeCtrlPkg::EXC_W-1:0] excId,
    input  pipeCtrlPkg::stallCtrl_t       ctrl,
    output pipeCtrlPkg::stageRec_t        recEx,
    output pipeCtrlPkg::stageRec_t        recMem,
    output pipeCtrlPkg::stageRec_t        recWb
);
    import pipeCtrlPkg::*;

    // one stage closer to the result, never below zero
    function automatic stageRec_t age(input stageRec_t rec);
        stageRec_t next;
        next = rec;
        if (rec.tnew != '0) begin
            next.tnew = rec.tnew - 1'b1;
        end
        return next;
    endfunction

    stageRec_t idRec;

    always_comb begin
        idRec.pc   = pcId;
        idRec.bd   = bdId;
        idRec.exc  = excId;
        idRec.dest = id.dest;
        idRec.tnew = id.tnew;
        idRec.op   = id.op;
    end

    // clrEx covers both the stall bubble and the flush
    always_ff @(posedge clk) begin
        if (rst || ctrl.clrEx) begin
            recEx <= BUBBLE;
        end else begin
            recEx <= age(idRec);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ctrl.clrMem) begin
            recMem <= BUBBLE;
        end else begin
            recMem <= age(recEx);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ctrl.clrWb) begin
            recWb <= BUBBLE;
        end else begin
            recWb <= age(recMem);
        end
    end

    // nop-like records must not look like a producer to the stall unit
    bubbleHasNoDest: assert property (
        @(posedge clk) disable iff (rst)
        ((recEx.op == OP_NOP || recEx.op == OP_UNKNOWN) |-> recEx.dest == '0) and
        ((recMem.op == OP_NOP || recMem.op == OP_UNKNOWN) |-> recMem.dest == '0) and
        ((recWb.op == OP_NOP || recWb.op == OP_UNKNOWN) |-> recWb.dest == '0)
    );

    // once the records are cleared by reset the control outputs must be quiet
    ctrlQuietInReset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> (ctrl == '0)
    );

endmodule

// ==== verilog/tuseTnewDecoder.sv ====
`timescale 1ns/1ns

module tuseTnewDecoder (
    input  pipeCtrlPkg::funcClass_e               func,
    input  pipeCtrlPkg::instrOp_e                 op,
    output logic [pipeCtrlPkg::TIME_W-1:0]        tuseRs,
    output logic [pipeCtrlPkg::TIME_W-1:0]        tuseRt,
    output logic [pipeCtrlPkg::TIME_W-1:0]        tnew
);
    import pipeCtrlPkg::*;

    always_comb begin
        tuseRs = TUSE_INF;
        tuseRt = TUSE_INF;
        tnew   = '0;
        case (func)
            FUNC_CALC_R: begin
                // shifts take the amount from shamt, rs is unused
                if (op != SLL && op != SRL && op != SRA) begin
                    tuseRs = TIME_W'(1);
                end
                tuseRt = TIME_W'(1);
                tnew   = TIME_W'(2);
            end
            FUNC_CALC_I: begin
                if (op == LUI) begin
                    tnew = TIME_W'(1);
                end else begin
                    tuseRs = TIME_W'(1);
                    tnew   = TIME_W'(2);
                end
            end
            FUNC_MEM_READ: begin
                tuseRs = TIME_W'(1);
                // lb would need 5 cycles in the full core, clipped to the lw value here
                tnew   = TIME_W'(3);
            end
            FUNC_MEM_WRITE: begin
                tuseRs = TIME_W'(1);
                tuseRt = TIME_W'(2);
            end
            FUNC_BRANCH: begin
                tuseRs = '0;
                if (op == BEQ || op == BNE) begin
                    tuseRt = '0;
                end
            end
            FUNC_JUMP: begin
                if (op == JR || op == JALR) begin
                    tuseRs = '0;
                end
                // link address is ready one stage early
                if (op == JAL || op == JALR) begin
                    tnew = TIME_W'(1);
                end
            end
            FUNC_CP0: begin
                if (op == MTC0) begin
                    tuseRt = TIME_W'(2);
                end
                if (op == MFC0) begin
                    tnew = TIME_W'(3);
                end
            end
            default: begin
                tnew = '0;
            end
        endcase
    end

endmodule
